//--- verilog.f
logic/ahb_apb_pkg.sv
logic/ahb_slave_port.sv
logic/apb_beat_sequencer.sv
logic/ahb_apb_bridge.sv
dv/apb_mem_model.sv
dv/tb_ahb_apb_bridge.sv

//--- Makefile
# Verilator build and run for the AHB to APB bridge testbench

TOP       ?= tb_ahb_apb_bridge
VERILATOR ?= verilator
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "ALL CHECKS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_ahb_apb_bridge.sv
/*
 * AHB to APB bridge testbench
 * Drives AHB transfers, models expected data, memory and APB
 * beats, and compares every completed transfer
 */
module tb_ahb_apb_bridge;
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_apb_pkg::*;

  localparam int PADDR_W  = 10;
  localparam int PDATA_W  = 8;
  localparam int PBYTES   = PDATA_W / 8;
  localparam int LOG_W    = 1 + 3 + PBYTES + PADDR_W;
  localparam int N_RANDOM = 48;
  // Directed 36 plus random
  localparam int N_XFERS  = 36 + N_RANDOM;
  // Four beats of up to five cycles each, plus slack
  localparam int CYCLE_LIMIT = N_XFERS * 4 * 5 + 200;
  localparam logic [PADDR_W-1:0] ERR_BASE = 10'h300;

  // One observed AHB transfer
  typedef struct packed {
    xfer_req_t          req;
    logic [HDATA_W-1:0] rdata;
    logic               resp;
    logic               err_low;
  } obs_t;

  logic HCLK;
  logic HRESETn;
  logic hsel;
  logic [HADDR_W-1:0] haddr;
  logic [HDATA_W-1:0] hwdata;
  logic hwrite;
  hsize_t hsize;
  logic [3:0] hprot;
  htrans_t htrans;
  logic hready;
  logic [HDATA_W-1:0] hrdata;
  logic hreadyout;
  logic hresp;
  logic psel;
  logic penable;
  pprot_t pprot;
  logic pwrite;
  logic [PBYTES-1:0] pstrb;
  logic [PADDR_W-1:0] paddr;
  logic [PDATA_W-1:0] pwdata;
  logic [PDATA_W-1:0] prdata;
  logic pready;
  logic pslverr;

  logic [7:0] shadow [1 << PADDR_W];
  obs_t       obs_q [$];
  event       xfer_done;
  int         cycles = 0;

  // Single slave, so hready loops back
  assign hready = hreadyout;

  ahb_apb_bridge #(
    .PADDR_W (PADDR_W),
    .PDATA_W (PDATA_W)
  ) i_ahb_apb_bridge (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .hsel (hsel), .haddr (haddr), .hwdata (hwdata), .hwrite (hwrite),
    .hsize (hsize), .hprot (hprot), .htrans (htrans), .hready (hready),
    .hrdata (hrdata), .hreadyout (hreadyout), .hresp (hresp),
    .psel (psel), .penable (penable), .pprot (pprot), .pwrite (pwrite),
    .pstrb (pstrb), .paddr (paddr), .pwdata (pwdata),
    .prdata (prdata), .pready (pready), .pslverr (pslverr)
  );

  apb_mem_model #(
    .PADDR_W  (PADDR_W),
    .PDATA_W  (PDATA_W),
    .ERR_BASE (ERR_BASE)
  ) i_mem (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .psel (psel), .penable (penable), .pprot (pprot), .pwrite (pwrite),
    .pstrb (pstrb), .paddr (paddr), .pwdata (pwdata),
    .prdata (prdata), .pready (pready), .pslverr (pslverr)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  always @(posedge HCLK)
  begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT)
      abort_run("Timeout: transfers did not finish within the cycle limit");
  end

  //////////////////////////////////////////////////
  // Failure and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run(string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(string name, logic [HDATA_W-1:0] got, logic [HDATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_resp(string name, logic got, logic exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_beat(logic [PADDR_W-1:0] got_addr, logic [PADDR_W-1:0] exp_addr,
                            logic [PBYTES-1:0] got_strb, logic [PBYTES-1:0] exp_strb,
                            pprot_t got_prot, pprot_t exp_prot,
                            logic got_write, logic exp_write);
    if (got_addr !== exp_addr)
      abort_run($sformatf("CHECK FAILED paddr got 0x%h expected 0x%h", got_addr, exp_addr));
    if (got_strb !== exp_strb)
      abort_run($sformatf("CHECK FAILED pstrb got 0x%h expected 0x%h", got_strb, exp_strb));
    if (got_prot !== exp_prot)
      abort_run($sformatf("CHECK FAILED pprot got 0x%h expected 0x%h", got_prot, exp_prot));
    if (got_write !== exp_write)
      abort_run($sformatf("CHECK FAILED pwrite got 0x%h expected 0x%h", got_write, exp_write));
  endtask

  function automatic logic [HDATA_W-1:0] mem_word(logic [PADDR_W-1:0] base);
    return {i_mem.mem[base + 3], i_mem.mem[base + 2], i_mem.mem[base + 1], i_mem.mem[base]};
  endfunction

  function automatic logic [HDATA_W-1:0] shadow_word(logic [PADDR_W-1:0] base);
    return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Expected hrdata, shadow memory updated for writes
  function automatic logic [HDATA_W-1:0] ref_xfer(xfer_req_t r, output logic err);
    logic [HDATA_W-1:0] rd;
    int base;
    int off;
    int nbytes;
    int i;
    base   = {r.addr[PADDR_W-1:2], 2'b00};
    off    = r.addr[1:0];
    nbytes = 1 << r.size;
    err    = (r.addr[PADDR_W-1:0] >= ERR_BASE);
    rd     = '0;
    for (i = 0; i < 4; i++)
      if (!err && (i >= off) && (i < off + nbytes))
      begin
        if (r.write)
          shadow[base + i] = r.wdata[i*8 +: 8];
        else
          rd[i*8 +: 8] = shadow[base + i];
      end
    return rd;
  endfunction

  task automatic compare_xfer(obs_t o);
    logic [HDATA_W-1:0] exp_rdata;
    logic               exp_err;
    logic [LOG_W-1:0]   entry;
    logic [PBYTES-1:0]  exp_strb;
    int off;
    int nbytes;
    int nbeats;
    int lane;
    int k;
    int j;
    exp_rdata = ref_xfer(o.req, exp_err);
    off       = o.req.addr[1:0];
    nbytes    = 1 << o.req.size;
    // Error ends the transfer on its first beat
    nbeats    = exp_err ? 1 : ((nbytes > PBYTES) ? nbytes / PBYTES : 1);
    check_resp("hresp", o.resp, exp_err ? HRESP_ERROR : HRESP_OKAY);
    check_resp("hresp_stalled", o.err_low, exp_err);
    if (!o.req.write && !exp_err)
      check_data("hrdata", o.rdata, exp_rdata);
    if (i_mem.beat_log.size() != nbeats)
      abort_run($sformatf("CHECK FAILED beat_count got 0x%0h expected 0x%0h",
                          i_mem.beat_log.size(), nbeats));
    for (k = 0; k < nbeats; k++)
    begin
      entry = i_mem.beat_log.pop_front();
      for (j = 0; j < PBYTES; j++)
      begin
        lane        = ((off + k * PBYTES) & ~(PBYTES - 1)) + j;
        exp_strb[j] = o.req.write && (lane >= off) && (lane < off + nbytes);
      end
      check_beat(entry[PADDR_W-1:0], PADDR_W'(o.req.addr[PADDR_W-1:0] + k * PBYTES),
                 entry[PADDR_W +: PBYTES], exp_strb,
                 entry[PADDR_W+PBYTES +: 3], {~o.req.prot[0], 1'b0, o.req.prot[1]},
                 entry[LOG_W-1], o.req.write);
    end
    check_data("mem_word", mem_word({o.req.addr[PADDR_W-1:2], 2'b00}),
               shadow_word({o.req.addr[PADDR_W-1:2], 2'b00}));
  endtask

  // Compare process, drains every observed transfer
  initial
  begin
    forever
    begin
      @(xfer_done);
      while (obs_q.size() != 0)
        compare_xfer(obs_q.pop_front());
    end
  end

  //////////////////////////////////////////////////
  // AHB stimulus
  //////////////////////////////////////////////////

  task automatic run_xfer(logic [HADDR_W-1:0] addr, logic write, hsize_t size,
                          logic [3:0] prot, logic [HDATA_W-1:0] wdata);
    obs_t o;
    @(posedge HCLK);
    #1;
    hsel   = 1'b1;
    haddr  = addr;
    hwrite = write;
    hsize  = size;
    hprot  = prot;
    htrans = HTRANS_NONSEQ;
    // Accepting edge, data phase follows
    @(posedge HCLK);
    #1;
    hsel      = 1'b0;
    htrans    = HTRANS_IDLE;
    hwdata    = wdata;
    o.err_low = 1'b0;
    @(negedge HCLK);
    while (!hreadyout)
    begin
      if (hresp == HRESP_ERROR)
        o.err_low = 1'b1;
      @(negedge HCLK);
    end
    o.req.addr  = addr;
    o.req.wdata = wdata;
    o.req.write = write;
    o.req.size  = size;
    o.req.prot  = prot;
    o.resp      = hresp;
    o.rdata     = hrdata;
    obs_q.push_back(o);
    -> xfer_done;
  endtask

  initial
  begin
    logic [HADDR_W-1:0] addr;
    hsize_t             size;
    int                 i;
    void'($urandom(32'h9e08));
    HRESETn = 1'b0;
    hsel    = 1'b0;
    haddr   = '0;
    hwdata  = '0;
    hwrite  = 1'b0;
    hsize   = HSIZE_BYTE;
    hprot   = 4'h0;
    htrans  = HTRANS_IDLE;
    repeat (16) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    for (i = 0; i < (1 << PADDR_W); i++)
      shadow[i] = i_mem.mem[i];

    // Idle state out of reset
    check_resp("hreadyout", hreadyout, 1'b1);
    check_resp("hresp", hresp, HRESP_OKAY);
    check_resp("psel", psel, 1'b0);
    check_resp("penable", penable, 1'b0);
    check_data("pstrb", HDATA_W'(pstrb), '0);

    // Word writes, four beats each
    run_xfer(32'h0000_0000, 1'b1, HSIZE_WORD, 4'h3, 32'h1122_3344);
    run_xfer(32'h0000_0004, 1'b1, HSIZE_WORD, 4'h1, 32'ha5c3_0f96);
    run_xfer(32'h0000_01f8, 1'b1, HSIZE_WORD, 4'h2, 32'h0bad_cafe);
    run_xfer(32'h0000_02fc, 1'b1, HSIZE_WORD, 4'h0, 32'h7e57_d00d);

    // Byte and halfword writes at each aligned offset
    for (i = 0; i < 4; i++)
      run_xfer(32'h80 + i, 1'b1, HSIZE_BYTE, 4'h1, $urandom);
    for (i = 0; i < 2; i++)
      run_xfer(32'h84 + 2 * i, 1'b1, HSIZE_HWORD, 4'h1, $urandom);

    // Reads of every size
    for (i = 0; i < 4; i++)
      run_xfer(32'h0 + i, 1'b0, HSIZE_BYTE, 4'h1, '0);
    for (i = 0; i < 2; i++)
      run_xfer(32'h84 + 2 * i, 1'b0, HSIZE_HWORD, 4'h1, '0);
    run_xfer(32'h40, 1'b0, HSIZE_WORD, 4'h1, '0);

    // Error region, then recovery
    run_xfer(32'h300, 1'b1, HSIZE_WORD, 4'h1, 32'hdead_beef);
    run_xfer(32'h3fd, 1'b0, HSIZE_BYTE, 4'h0, '0);
    run_xfer(32'h2fc, 1'b0, HSIZE_WORD, 4'h1, '0);

    // Every HPROT value
    for (i = 0; i < 16; i++)
      run_xfer(32'h100 + 4 * i + 2 * (i % 2), 1'b1, HSIZE_HWORD, 4'(i), $urandom);

    // Random mix over the whole map
    for (i = 0; i < N_RANDOM; i++)
    begin
      size = hsize_t'(3'($urandom % 3));
      addr = $urandom;
      if (size == HSIZE_HWORD)
        addr[0] = 1'b0;
      else if (size == HSIZE_WORD)
        addr[1:0] = 2'b00;
      run_xfer(addr, 1'($urandom), size, 4'($urandom), $urandom);
    end

    @(negedge HCLK);
    // Whole memory against the shadow copy
    for (i = 0; i < (1 << PADDR_W); i += 4)
      check_data("mem_word", mem_word(PADDR_W'(i)), shadow_word(PADDR_W'(i)));
    if (obs_q.size() != 0)
      abort_run("Some completed transfers were never compared");
    else
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- dv/apb_mem_model.sv
/*
 * APB slave memory model
 * Byte store with random wait states per beat, an error
 * region at the top of the map, and a log of every beat
 */
module apb_mem_model #(
  parameter int                 PADDR_W  = 10,
  parameter int                 PDATA_W  = 8,
  parameter logic [PADDR_W-1:0] ERR_BASE = 'h300
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 psel,
  input  logic                 penable,
  input  ahb_apb_pkg::pprot_t  pprot,
  input  logic                 pwrite,
  input  logic [PDATA_W/8-1:0] pstrb,
  input  logic [PADDR_W-1:0]   paddr,
  input  logic [PDATA_W-1:0]   pwdata,
  output logic [PDATA_W-1:0]   prdata,
  output logic                 pready,
  output logic                 pslverr
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PBYTES = PDATA_W / 8;
  localparam int DEPTH  = 1 << PADDR_W;
  // Log entry {pwrite, pprot, pstrb, paddr}
  localparam int LOG_W  = 1 + 3 + PBYTES + PADDR_W;

  logic [7:0]       mem [DEPTH];
  logic [LOG_W-1:0] beat_log [$];
  logic [1:0]       wait_cnt;
  logic             beat_end;

  initial
  begin
    // Fill pattern mixes every address bit
    for (int a = 0; a < DEPTH; a++)
      mem[a] = 8'(a * 29 + (a >> 8) * 101);
  end

  // Access phase ends on the cycle the count runs out
  assign pready   = (wait_cnt == 2'd0);
  assign beat_end = psel && penable && pready;
  assign pslverr  = beat_end && (paddr >= ERR_BASE);

  always_comb
    for (int j = 0; j < PBYTES; j++)
      prdata[j*8 +: 8] = mem[PADDR_W'(paddr + j)];

  // New wait count drawn in each setup cycle
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
      wait_cnt <= 2'd0;
    else if (psel && !penable)
      wait_cnt <= 2'($urandom % 4);
    else if (psel && penable && (wait_cnt != 2'd0))
      wait_cnt <= wait_cnt - 2'd1;

  //////////////////////////////////////////////////
  // Beat log and write port
  //////////////////////////////////////////////////

  always @(posedge HCLK)
    if (beat_end)
    begin
      beat_log.push_back({pwrite, pprot, pstrb, paddr});
      // Erroring beats leave memory alone
      if (pwrite && !pslverr)
        for (int j = 0; j < PBYTES; j++)
          if (pstrb[j])
            mem[PADDR_W'(paddr + j)] <= pwdata[j*8 +: 8];
    end

endmodule

//--- logic/ahb_apb_bridge.sv
/*
 * AHB3-Lite slave to APB4 master bridge, top level
 * Joins the AHB data-phase port to the APB beat sequencer
 */
module ahb_apb_bridge #(
  parameter int PADDR_W = 10,
  parameter int PDATA_W = 8
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,

  // AHB slave side
  input  logic                            hsel,
  input  logic [ahb_apb_pkg::HADDR_W-1:0] haddr,
  input  logic [ahb_apb_pkg::HDATA_W-1:0] hwdata,
  input  logic                            hwrite,
  input  ahb_apb_pkg::hsize_t             hsize,
  input  logic [3:0]                      hprot,
  input  ahb_apb_pkg::htrans_t            htrans,
  input  logic                            hready,
  output logic [ahb_apb_pkg::HDATA_W-1:0] hrdata,
  output logic                            hreadyout,
  output logic                            hresp,

  // APB master side
  output logic                            psel,
  output logic                            penable,
  output ahb_apb_pkg::pprot_t             pprot,
  output logic                            pwrite,
  output logic [PDATA_W/8-1:0]            pstrb,
  output logic [PADDR_W-1:0]              paddr,
  output logic [PDATA_W-1:0]              pwdata,
  input  logic [PDATA_W-1:0]              prdata,
  input  logic                            pready,
  input  logic                            pslverr
);
  import ahb_apb_pkg::*;

  // One transfer in flight between the two halves
  xfer_req_t req;
  logic      req_start;
  xfer_rsp_t rsp;
  logic      rsp_done;

  ahb_slave_port i_ahb_slave_port (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hprot     (hprot),
    .htrans    (htrans),
    .hready    (hready),
    .rsp       (rsp),
    .rsp_done  (rsp_done),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .req       (req),
    .req_start (req_start)
  );

  apb_beat_sequencer #(
    .PADDR_W (PADDR_W),
    .PDATA_W (PDATA_W)
  ) i_apb_beat_sequencer (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .req       (req),
    .req_start (req_start),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .psel      (psel),
    .penable   (penable),
    .pprot     (pprot),
    .pwrite    (pwrite),
    .pstrb     (pstrb),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .rsp       (rsp),
    .rsp_done  (rsp_done)
  );

endmodule

//--- logic/apb_beat_sequencer.sv
/*
 * APB4 master beat sequencer
 * Splits one captured AHB transfer into beats on a narrower
 * APB bus, drives lanes and strobes, and gathers read bytes
 */
module apb_beat_sequencer #(
  parameter int PADDR_W = 10,
  parameter int PDATA_W = 8
) (
  input  logic                   HCLK,
  input  logic                   HRESETn,

  // Transfer from the AHB side
  input  ahb_apb_pkg::xfer_req_t req,
  input  logic                   req_start,

  // APB master
  input  logic [PDATA_W-1:0]     prdata,
  input  logic                   pready,
  input  logic                   pslverr,
  output logic                   psel,
  output logic                   penable,
  output ahb_apb_pkg::pprot_t    pprot,
  output logic                   pwrite,
  output logic [PDATA_W/8-1:0]   pstrb,
  output logic [PADDR_W-1:0]     paddr,
  output logic [PDATA_W-1:0]     pwdata,

  // Completion back to the AHB side
  output ahb_apb_pkg::xfer_rsp_t rsp,
  output logic                   rsp_done
);
  import ahb_apb_pkg::*;

  // APB byte lanes
  localparam int PBYTES = PDATA_W / 8;
  // Clears the lane bits of a byte offset
  localparam logic [1:0] BASE_MASK = 2'(~(PBYTES - 1));

  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_SETUP  = 2'b01,
    ST_ACCESS = 2'b10
  } seq_state_t;

  seq_state_t         state;
  logic [1:0]         beats_left;
  logic [1:0]         byte_off;
  logic [HDATA_W-1:0] rd_acc;
  logic [HDATA_W-1:0] rd_next;

  logic               load_first;
  logic               load_next;
  logic               finish;
  logic [3:0]         req_lanes;
  logic [1:0]         nxt_off;
  logic [1:0]         nxt_base;
  logic [1:0]         cur_base;
  logic [PBYTES-1:0]  nxt_lanes;
  logic [PBYTES-1:0]  cur_lanes;
  logic [PDATA_W-1:0] nxt_wdata;

  // Beats after the first one
  function automatic logic [1:0] beats_left_init(hsize_t size);
    logic [2:0] nbeats;
    nbeats = size_bytes(size) / 3'(PBYTES);
    if (nbeats == 3'd0)
      nbeats = 3'd1;
    return 2'(nbeats - 3'd1);
  endfunction

  // Bytes touched within the 32-bit word
  function automatic logic [3:0] word_lanes(hsize_t size, logic [1:0] off);
    logic [3:0] ones;
    case (size)
      HSIZE_BYTE:  ones = 4'b0001;
      HSIZE_HWORD: ones = 4'b0011;
      default:     ones = 4'b1111;
    endcase
    return ones << off;
  endfunction

  //////////////////////////////////////////////////
  // Beat arithmetic
  //////////////////////////////////////////////////

  assign load_first = (state == ST_IDLE) && req_start;
  assign finish     = (state == ST_ACCESS) && pready &&
                      (pslverr || (beats_left == 2'd0));
  assign load_next  = (state == ST_ACCESS) && pready && !finish;

  assign req_lanes = word_lanes(req.size, req.addr[1:0]);

  // Offset of the beat being set up; wraps only on single-beat transfers
  assign nxt_off   = (state == ST_IDLE) ? req.addr[1:0] : byte_off + 2'(PBYTES);
  assign nxt_base  = nxt_off & BASE_MASK;
  assign nxt_lanes = req_lanes[nxt_base +: PBYTES];
  assign nxt_wdata = req.wdata[nxt_base*8 +: PDATA_W];

  // Lanes of the beat now in its access phase
  assign cur_base  = byte_off & BASE_MASK;
  assign cur_lanes = req_lanes[cur_base +: PBYTES];

  // Merge returned bytes at their word offsets
  always_comb
  begin
    rd_next = rd_acc;
    for (int j = 0; j < PBYTES; j++)
      if (cur_lanes[j])
        rd_next[(cur_base + j)*8 +: 8] = prdata[j*8 +: 8];
  end

  //////////////////////////////////////////////////
  // APB FSM
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      state      <= ST_IDLE;
      psel       <= 1'b0;
      penable    <= 1'b0;
      pstrb      <= '0;
      beats_left <= 2'd0;
      byte_off   <= 2'd0;
      rsp_done   <= 1'b0;
    end
    else
    begin
      rsp_done <= 1'b0;

      case (state)
        ST_IDLE:
          if (req_start)
          begin
            state      <= ST_SETUP;
            psel       <= 1'b1;
            pstrb      <= nxt_lanes & {PBYTES{req.write}};
            beats_left <= beats_left_init(req.size);
            byte_off   <= nxt_off;
          end

        ST_SETUP:
        begin
          state   <= ST_ACCESS;
          penable <= 1'b1;
        end

        ST_ACCESS:
          if (finish)
          begin
            // Last beat or slave error ends the transfer
            state    <= ST_IDLE;
            psel     <= 1'b0;
            penable  <= 1'b0;
            pstrb    <= '0;
            rsp_done <= 1'b1;
          end
          else if (load_next)
          begin
            state      <= ST_SETUP;
            penable    <= 1'b0;
            pstrb      <= nxt_lanes & {PBYTES{req.write}};
            beats_left <= beats_left - 2'd1;
            byte_off   <= nxt_off;
          end

        default: state <= ST_IDLE;
      endcase
    end

  //////////////////////////////////////////////////
  // Beat payload and result
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK)
  begin
    if (load_first)
    begin
      pwrite <= req.write;
      pprot  <= pprot_map(req.prot);
      paddr  <= req.addr[PADDR_W-1:0];
      pwdata <= nxt_wdata;
      rd_acc <= '0;
    end
    else if (load_next)
    begin
      // Next beat sits one APB word higher
      paddr  <= paddr + PADDR_W'(PBYTES);
      pwdata <= nxt_wdata;
      rd_acc <= rd_next;
    end

    if (finish)
    begin
      rsp.rdata <= rd_next;
      rsp.err   <= pslverr;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_enable_sel: assert property (@(posedge HCLK) disable iff (!HRESETn)
    penable |-> psel);

  // Wait states freeze the whole access phase
  a_hold_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (penable && !pready) |=>
      $stable({psel, penable, pprot, pwrite, pstrb, paddr, pwdata}));

endmodule

//--- logic/ahb_slave_port.sv
/*
 * AHB3-Lite slave port
 * Captures one transfer, holds the master with hreadyout,
 * and returns OKAY or a two-cycle ERROR on completion
 */
module ahb_slave_port (
  input  logic                            HCLK,
  input  logic                            HRESETn,

  // AHB address and data phase
  input  logic                            hsel,
  input  logic [ahb_apb_pkg::HADDR_W-1:0] haddr,
  input  logic [ahb_apb_pkg::HDATA_W-1:0] hwdata,
  input  logic                            hwrite,
  input  ahb_apb_pkg::hsize_t             hsize,
  input  logic [3:0]                      hprot,
  input  ahb_apb_pkg::htrans_t            htrans,
  input  logic                            hready,

  // Completion from the APB side
  input  ahb_apb_pkg::xfer_rsp_t          rsp,
  input  logic                            rsp_done,

  output logic [ahb_apb_pkg::HDATA_W-1:0] hrdata,
  output logic                            hreadyout,
  output logic                            hresp,

  // Request to the APB side
  output ahb_apb_pkg::xfer_req_t          req,
  output logic                            req_start
);
  import ahb_apb_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE      = 2'b00,
    ST_WAIT_DATA = 2'b01,
    ST_BUSY      = 2'b10,
    ST_ERROR2    = 2'b11
  } port_state_t;

  port_state_t state;
  logic        accept;

  // Valid address phase aimed at this slave
  assign accept = hsel && hready &&
                  ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      state     <= ST_IDLE;
      hreadyout <= 1'b1;
      hresp     <= HRESP_OKAY;
      req_start <= 1'b0;
    end
    else
    begin
      // Start strobe lasts one cycle
      req_start <= 1'b0;

      case (state)
        ST_IDLE:
        begin
          hresp <= HRESP_OKAY;
          if (accept)
          begin
            // Stall the data phase until APB finishes
            state     <= ST_WAIT_DATA;
            hreadyout <= 1'b0;
          end
          else
            hreadyout <= 1'b1;
        end

        ST_WAIT_DATA:
        begin
          // hwdata is valid now, hand off
          state     <= ST_BUSY;
          req_start <= 1'b1;
        end

        ST_BUSY:
          if (rsp_done)
          begin
            if (rsp.err)
            begin
              // First ERROR cycle, still stalled
              state <= ST_ERROR2;
              hresp <= HRESP_ERROR;
            end
            else
            begin
              state     <= ST_IDLE;
              hreadyout <= 1'b1;
            end
          end

        ST_ERROR2:
        begin
          // Second ERROR cycle releases the master
          state     <= ST_IDLE;
          hreadyout <= 1'b1;
        end

        default: state <= ST_IDLE;
      endcase
    end

  //////////////////////////////////////////////////
  // Transfer capture
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK)
  begin
    // Address phase fields
    if ((state == ST_IDLE) && accept)
    begin
      req.addr  <= haddr;
      req.write <= hwrite;
      req.size  <= hsize;
      req.prot  <= hprot;
    end

    // Data phase one cycle later
    if (state == ST_WAIT_DATA)
      req.wdata <= hwdata;

    // Read data only on a good completion
    if ((state == ST_BUSY) && rsp_done && !rsp.err)
      hrdata <= rsp.rdata;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Master must align to the transfer size
  a_aligned: assert property (@(posedge HCLK) disable iff (!HRESETn)
    accept |-> ((haddr[1:0] & (size_bytes(hsize) - 3'd1)) == 3'd0));

  // hready loop must keep new address phases out while stalled
  a_no_overlap: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (state != ST_IDLE) |-> !accept);

endmodule

//--- logic/ahb_apb_pkg.sv
/*
 * AHB to APB bridge shared definitions
 * Bus widths, AHB encodings, transfer request and response
 * structs, and helpers for beat sizing and protection mapping
 */
package ahb_apb_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // AHB side is fixed at one 32-bit word
  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;

  //////////////////////////////////////////////////
  // AHB encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // Only sizes up to one word are carried
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // HPROT bit positions
  localparam int HPROT_DATA = 0;
  localparam int HPROT_PRIV = 1;

  // APB protection: {instruction, nonsecure, privileged}
  typedef logic [2:0] pprot_t;

  //////////////////////////////////////////////////
  // Transfer request and response
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [HADDR_W-1:0] addr;
    logic [HDATA_W-1:0] wdata;
    logic               write;
    hsize_t             size;
    logic [3:0]         prot;
  } xfer_req_t;

  typedef struct packed {
    logic [HDATA_W-1:0] rdata;
    logic               err;
  } xfer_rsp_t;

  // Bytes moved by one transfer of the given size
  function automatic logic [2:0] size_bytes(hsize_t size);
    case (size)
      HSIZE_BYTE:  return 3'd1;
      HSIZE_HWORD: return 3'd2;
      default:     return 3'd4;
    endcase
  endfunction

  // HPROT to PPROT, always reported as secure
  function automatic pprot_t pprot_map(logic [3:0] hprot);
    pprot_t p;
    p[0] = hprot[HPROT_PRIV];
    p[1] = 1'b0;
    p[2] = ~hprot[HPROT_DATA];
    return p;
  endfunction

endpackage
